/* hw/lgcmp_pkg.sv */
// Logic and compare issue path widths, operation encoding and payload structs
`default_nettype none

package lgcmp_pkg;

	localparam int xlen = 64;
	localparam int rename_bits = 1; // Rename copies per architectural register, as a bit count
	localparam int arch_bits = 5;
	localparam int preg_bits = arch_bits + rename_bits;
	localparam int npreg = 32 << rename_bits;

	// Architectural index in the upper bits, rename copy in the lower bits
	typedef logic [preg_bits-1:0] preg_t;

	typedef enum logic [3:0] {
		op_slti  = 4'd0,
		op_sltiu = 4'd1,
		op_slt   = 4'd2,
		op_sltu  = 4'd3,
		op_xori  = 4'd4,
		op_ori   = 4'd5,
		op_andi  = 4'd6,
		op_xor   = 4'd7,
		op_or    = 4'd8,
		op_and   = 4'd9
	} lgcmp_op_t;

	// ----------------------------------------------------------
	// Payloads
	// ----------------------------------------------------------

	// One-hot function class seen by execute
	typedef struct packed {
		logic is_slt;
		logic is_xor;
		logic is_or;
		logic is_and;
	} lgcmp_fun_t;

	typedef struct packed {
		lgcmp_op_t       op;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] imm; // Already sign extended by decode
		preg_t           rd;
		preg_t           rs1;
		preg_t           rs2;
	} lgcmp_info_t;

	typedef struct packed {
		lgcmp_fun_t      fun;
		logic            is_unsigned;
		preg_t           rd;
		logic [xlen-1:0] op1;
		logic [xlen-1:0] op2;
	} lgcmp_exeparam_t;

	typedef struct packed {
		preg_t           rd;
		logic [xlen-1:0] data;
	} lgcmp_wb_t;

endpackage

`default_nettype wire

/* hw/lgcmp_issue_buffer.sv */
// Logic and compare issue buffer holding dispatched entries until they are selected
`timescale 1ns/1ps
`default_nettype none

module lgcmp_issue_buffer #(
	parameter int DP = 4
) (
	input wire CLK,
	input wire reset,
	input wire flush,

	input wire dispatch_valid,
	input wire lgcmp_pkg::lgcmp_info_t dispatch_info,
	output logic dispatch_full,

	output logic alloc_valid,
	output lgcmp_pkg::preg_t alloc_rd,

	input wire pop,
	input wire [$clog2(DP)-1:0] pop_index,
	output logic [DP-1:0] malloc,
	output lgcmp_pkg::lgcmp_info_t entries [DP]
);

	localparam int iw = $clog2(DP);

	logic [iw-1:0] free_index;

	// ----------------------------------------------------------
	// Slot allocation
	// ----------------------------------------------------------

	// Walk down so the lowest free slot is the one left standing
	always_comb begin
		free_index = '0;
		for (int i = DP - 1; i >= 0; i--) begin
			if (!malloc[i]) begin
				free_index = iw'(i);
			end
		end
	end

	assign dispatch_full = &malloc;

	// A dispatch in a flush cycle is dropped along with the rest of the buffer
	assign alloc_valid = dispatch_valid & ~dispatch_full & ~flush;
	assign alloc_rd = dispatch_info.rd;

	// The popped slot is always allocated and the free slot never is, so
	// both updates can land in the same cycle
	always_ff @(posedge CLK) begin
		if (reset) begin
			malloc <= '0;
		end else if (flush) begin
			malloc <= '0;
		end else begin
			if (pop) begin
				malloc[pop_index] <= 1'b0;
			end
			if (alloc_valid) begin
				malloc[free_index] <= 1'b1;
			end
		end
	end

	// ----------------------------------------------------------
	// Entry storage
	// ----------------------------------------------------------

	always_ff @(posedge CLK) begin
		if (alloc_valid) begin
			entries[free_index] <= dispatch_info;
		end
	end

endmodule

`default_nettype wire

/* hw/lgcmp_issue.sv */
// Logic and compare issue stage with wakeup, oldest-free select and operand read
`timescale 1ns/1ps
`default_nettype none

module lgcmp_issue #(
	parameter int DP = 4
) (
	input wire CLK,
	input wire reset,
	input wire flush,

	input wire [DP-1:0] malloc,
	input wire lgcmp_pkg::lgcmp_info_t entries [DP],
	output logic pop,
	output logic [$clog2(DP)-1:0] pop_index,

	input wire [lgcmp_pkg::xlen-1:0] regs [lgcmp_pkg::npreg],
	input wire [lgcmp_pkg::npreg-1:0] written,

	output logic exeparam_valid,
	output lgcmp_pkg::lgcmp_exeparam_t exeparam
);

	import lgcmp_pkg::*;

	localparam int iw = $clog2(DP);

	lgcmp_fun_t fun [DP];
	logic [DP-1:0] is_imm;
	logic [DP-1:0] is_unsigned;
	logic [DP-1:0] rs1_ready;
	logic [DP-1:0] rs2_ready;
	logic [DP-1:0] clear_raw;

	logic [iw-1:0] sel;
	logic any_clear;
	lgcmp_info_t sel_entry;

	// ----------------------------------------------------------
	// Decode and wakeup per slot
	// ----------------------------------------------------------

	always_comb begin
		for (int i = 0; i < DP; i++) begin
			fun[i].is_slt = entries[i].op inside {op_slti, op_sltiu, op_slt, op_sltu};
			fun[i].is_xor = entries[i].op inside {op_xori, op_xor};
			fun[i].is_or  = entries[i].op inside {op_ori, op_or};
			fun[i].is_and = entries[i].op inside {op_andi, op_and};

			is_imm[i] = entries[i].op inside {op_slti, op_sltiu, op_xori, op_ori, op_andi};
			is_unsigned[i] = entries[i].op inside {op_sltiu, op_sltu};

			// x0 never waits on anything
			rs1_ready[i] = written[entries[i].rs1]
				| (entries[i].rs1[rename_bits +: arch_bits] == '0);
			rs2_ready[i] = written[entries[i].rs2]
				| (entries[i].rs2[rename_bits +: arch_bits] == '0);

			clear_raw[i] = malloc[i] & rs1_ready[i] & (rs2_ready[i] | is_imm[i]);
		end
	end

	// ----------------------------------------------------------
	// Select
	// ----------------------------------------------------------

	always_comb begin
		sel = '0;
		any_clear = 1'b0;
		for (int i = DP - 1; i >= 0; i--) begin
			if (clear_raw[i]) begin
				sel = iw'(i);
				any_clear = 1'b1;
			end
		end
	end

	assign sel_entry = entries[sel];

	assign pop = any_clear & ~flush; // Execute never stalls, so a clear entry always leaves
	assign pop_index = sel;

	// ----------------------------------------------------------
	// Execute parameters
	// ----------------------------------------------------------

	always_ff @(posedge CLK) begin
		if (reset) begin
			exeparam_valid <= 1'b0;
		end else begin
			exeparam_valid <= pop;
		end
	end

	always_ff @(posedge CLK) begin
		if (pop) begin
			exeparam.fun <= fun[sel];
			exeparam.is_unsigned <= is_unsigned[sel];
			exeparam.rd <= sel_entry.rd;
			exeparam.op1 <= regs[sel_entry.rs1];
			exeparam.op2 <= is_imm[sel] ? sel_entry.imm : regs[sel_entry.rs2];
		end
	end

endmodule

`default_nettype wire

/* hw/lgcmp_execute.sv */
// Logic and compare execute unit computing set-less-than and bitwise results
`timescale 1ns/1ps
`default_nettype none

module lgcmp_execute (
	input wire CLK,
	input wire reset,
	input wire flush,

	input wire exeparam_valid,
	input wire lgcmp_pkg::lgcmp_exeparam_t exeparam,

	output logic wb_valid,
	output lgcmp_pkg::lgcmp_wb_t wb
);

	import lgcmp_pkg::*;

	logic less_than;
	logic [xlen-1:0] result;

	always_comb begin
		if (exeparam.is_unsigned) begin
			less_than = exeparam.op1 < exeparam.op2;
		end else begin
			less_than = $signed(exeparam.op1) < $signed(exeparam.op2);
		end

		// Function bits are one-hot so the terms can simply be or'ed
		result = ({xlen{exeparam.fun.is_slt}} & {{(xlen-1){1'b0}}, less_than})
			| ({xlen{exeparam.fun.is_xor}} & (exeparam.op1 ^ exeparam.op2))
			| ({xlen{exeparam.fun.is_or}}  & (exeparam.op1 | exeparam.op2))
			| ({xlen{exeparam.fun.is_and}} & (exeparam.op1 & exeparam.op2));
	end

	// ----------------------------------------------------------
	// Writeback register
	// ----------------------------------------------------------

	always_ff @(posedge CLK) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= exeparam_valid & ~flush; // In-flight result dies with the flush
		end
	end

	always_ff @(posedge CLK) begin
		if (exeparam_valid) begin
			wb.rd <= exeparam.rd;
			wb.data <= result;
		end
	end

endmodule

`default_nettype wire

/* hw/lgcmp_phys_regfile.sv */
// Physical register file with a written-back flag per register
`timescale 1ns/1ps
`default_nettype none

module lgcmp_phys_regfile (
	input wire CLK,
	input wire reset,

	input wire alloc_valid,
	input wire lgcmp_pkg::preg_t alloc_rd,

	input wire wb_valid,
	input wire lgcmp_pkg::lgcmp_wb_t wb,
	input wire ext_wb_valid,
	input wire lgcmp_pkg::lgcmp_wb_t ext_wb,

	output logic [lgcmp_pkg::xlen-1:0] regs [lgcmp_pkg::npreg],
	output logic [lgcmp_pkg::npreg-1:0] written
);

	import lgcmp_pkg::*;

	logic exe_we;
	logic ext_we;

	// Copies of x0 are never written, so they keep reading zero
	assign exe_we = wb_valid & (wb.rd[rename_bits +: arch_bits] != '0);
	assign ext_we = ext_wb_valid & (ext_wb.rd[rename_bits +: arch_bits] != '0);

	// ----------------------------------------------------------
	// Register values
	// ----------------------------------------------------------

	// Execute is written last so it wins a same-register collision
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < npreg; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (ext_we) begin
				regs[ext_wb.rd] <= ext_wb.data;
			end
			if (exe_we) begin
				regs[wb.rd] <= wb.data;
			end
		end
	end

	// ----------------------------------------------------------
	// Written-back flags
	// ----------------------------------------------------------

	always_ff @(posedge CLK) begin
		if (reset) begin
			written <= '1; // Nothing is pending out of reset
		end else begin
			if (ext_wb_valid) begin
				written[ext_wb.rd] <= 1'b1;
			end
			if (wb_valid) begin
				written[wb.rd] <= 1'b1;
			end
			// A fresh allocation overrides any writeback to the same register
			if (alloc_valid) begin
				written[alloc_rd] <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/lgcmp_top.sv */
// Logic and compare issue path top joining buffer, issue, execute and register file
`timescale 1ns/1ps
`default_nettype none

module lgcmp_top #(
	parameter int DP = 4
) (
	input wire CLK,
	input wire reset,
	input wire flush,

	input wire dispatch_valid,
	input wire lgcmp_pkg::lgcmp_info_t dispatch_info,
	output logic dispatch_full,

	input wire ext_wb_valid,
	input wire lgcmp_pkg::lgcmp_wb_t ext_wb,

	output logic wb_valid,
	output lgcmp_pkg::lgcmp_wb_t wb
);

	import lgcmp_pkg::*;

	logic alloc_valid;
	preg_t alloc_rd;

	logic [DP-1:0] malloc;
	lgcmp_info_t entries [DP];
	logic pop;
	logic [$clog2(DP)-1:0] pop_index;

	logic [xlen-1:0] regs [npreg];
	logic [npreg-1:0] written;

	logic exeparam_valid;
	lgcmp_exeparam_t exeparam;

	lgcmp_issue_buffer #(
		.DP(DP)
	) buffer_inst (
		.CLK(CLK),
		.reset(reset),
		.flush(flush),
		.dispatch_valid(dispatch_valid),
		.dispatch_info(dispatch_info),
		.dispatch_full(dispatch_full),
		.alloc_valid(alloc_valid),
		.alloc_rd(alloc_rd),
		.pop(pop),
		.pop_index(pop_index),
		.malloc(malloc),
		.entries(entries)
	);

	lgcmp_issue #(
		.DP(DP)
	) issue_inst (
		.CLK(CLK),
		.reset(reset),
		.flush(flush),
		.malloc(malloc),
		.entries(entries),
		.pop(pop),
		.pop_index(pop_index),
		.regs(regs),
		.written(written),
		.exeparam_valid(exeparam_valid),
		.exeparam(exeparam)
	);

	lgcmp_execute execute_inst (
		.CLK(CLK),
		.reset(reset),
		.flush(flush),
		.exeparam_valid(exeparam_valid),
		.exeparam(exeparam),
		.wb_valid(wb_valid),
		.wb(wb)
	);

	lgcmp_phys_regfile regfile_inst (
		.CLK(CLK),
		.reset(reset),
		.alloc_valid(alloc_valid),
		.alloc_rd(alloc_rd),
		.wb_valid(wb_valid),
		.wb(wb),
		.ext_wb_valid(ext_wb_valid),
		.ext_wb(ext_wb),
		.regs(regs),
		.written(written)
	);

endmodule

`default_nettype wire

/* bench/lgcmp_properties.sv */
// Concurrent checks on reset, flush and wakeup behavior of the issue path
`timescale 1ns/1ps
`default_nettype none

module lgcmp_properties #(
	parameter int DP = 4
) (
	input wire CLK,
	input wire reset,
	input wire flush,
	input wire dispatch_full,
	input wire [DP-1:0] malloc,
	input wire lgcmp_pkg::lgcmp_info_t entries [DP],
	input wire pop,
	input wire [$clog2(DP)-1:0] pop_index,
	input wire [lgcmp_pkg::npreg-1:0] written,
	input wire exeparam_valid,
	input wire wb_valid
);

	import lgcmp_pkg::*;

	logic property_failed = 1'b0; // Polled by the testbench
	lgcmp_info_t sel_entry;
	logic sel_imm;
	logic src_ok;

	assign sel_entry = entries[pop_index];
	assign sel_imm = sel_entry.op inside {op_slti, op_sltiu, op_xori, op_ori, op_andi};
	assign src_ok = (written[sel_entry.rs1] || sel_entry.rs1[preg_bits-1:rename_bits] == '0)
		&& (sel_imm || written[sel_entry.rs2] || sel_entry.rs2[preg_bits-1:rename_bits] == '0);

	// ----------------------------------------------------------
	// Reset and flush
	// ----------------------------------------------------------

	a_reset_quiet: assert property (@(posedge CLK)
		reset |=> !dispatch_full && !wb_valid && malloc == '0)
		else begin
			$error("Issue path not idle after reset");
			property_failed = 1'b1;
		end

	a_flush_quiet: assert property (@(posedge CLK) disable iff (reset)
		flush |=> !wb_valid && !exeparam_valid && malloc == '0)
		else begin
			$error("Work survived a flush");
			property_failed = 1'b1;
		end

	// ----------------------------------------------------------
	// Wakeup and select
	// ----------------------------------------------------------

	a_src_ready: assert property (@(posedge CLK) disable iff (reset)
		exeparam_valid |-> $past(pop && src_ok))
		else begin
			$error("Issued entry had a source that was not written back");
			property_failed = 1'b1;
		end

endmodule

bind lgcmp_top lgcmp_properties #(.DP(DP)) props_inst (
	.CLK(CLK),
	.reset(reset),
	.flush(flush),
	.dispatch_full(dispatch_full),
	.malloc(malloc),
	.entries(entries),
	.pop(pop),
	.pop_index(pop_index),
	.written(written),
	.exeparam_valid(exeparam_valid),
	.wb_valid(wb_valid)
);

`default_nettype wire

/* bench/lgcmp_tb.sv */
// Testbench for the logic and compare issue path with a reference model of the ten operations
`timescale 1ns/1ps
`default_nettype none

module lgcmp_tb;

	import lgcmp_pkg::*;

	localparam int DP = 4;
	localparam int max_cycles = 4000;

	logic CLK;
	logic reset;
	logic flush;
	logic dispatch_valid;
	lgcmp_info_t dispatch_info;
	logic dispatch_full;
	logic ext_wb_valid;
	lgcmp_wb_t ext_wb;
	logic wb_valid;
	lgcmp_wb_t wb;

	logic [31:0] lcg_state;
	int cycle_count = 0;
	int accepted = 0;
	int wb_count = 0;

	// Reference model, one slot per physical register
	logic [xlen-1:0] model_regs [npreg];
	logic [xlen-1:0] expected [npreg];
	bit known [npreg];
	bit pending [npreg];
	int readers [npreg]; // In-flight instructions that still read this register
	preg_t src1 [npreg];
	preg_t src2 [npreg];
	preg_t last_rd;
	preg_t hold;
	preg_t fill_src;
	preg_t gate;
	preg_t kill_rd [2];
	logic [xlen-1:0] hold_value;

	lgcmp_top #(
		.DP(DP)
	) lgcmp_top_inst (
		.CLK(CLK),
		.reset(reset),
		.flush(flush),
		.dispatch_valid(dispatch_valid),
		.dispatch_info(dispatch_info),
		.dispatch_full(dispatch_full),
		.ext_wb_valid(ext_wb_valid),
		.ext_wb(ext_wb),
		.wb_valid(wb_valid),
		.wb(wb)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [xlen-1:0] rand64();
		return {lcg_next(), lcg_next()};
	endfunction

	function automatic logic [xlen-1:0] reference_result(input lgcmp_op_t op,
		input logic [xlen-1:0] a, input logic [xlen-1:0] b, input logic [xlen-1:0] imm);
		case (op)
			op_slti:  return xlen'($signed(a) < $signed(imm));
			op_sltiu: return xlen'(a < imm);
			op_slt:   return xlen'($signed(a) < $signed(b));
			op_sltu:  return xlen'(a < b);
			op_xori:  return a ^ imm;
			op_ori:   return a | imm;
			op_andi:  return a & imm;
			op_xor:   return a ^ b;
			op_or:    return a | b;
			op_and:   return a & b;
			default:  return '0;
		endcase
	endfunction

	// Upper LCG bits, the low ones repeat too quickly
	function automatic preg_t pick_source();
		preg_t r;
		r = preg_t'(lcg_next() >> 26);
		while (!known[r]) begin
			r = preg_t'(lcg_next() >> 26);
		end
		return r;
	endfunction

	function automatic preg_t pick_dest(input preg_t a, input preg_t b);
		preg_t r;
		r = preg_t'(lcg_next() >> 26);
		while (r < 2 || pending[r] || readers[r] != 0 || r == a || r == b) begin
			r = preg_t'(lcg_next() >> 26);
		end
		return r;
	endfunction

	function automatic logic [xlen-1:0] rand_imm();
		logic [11:0] imm12;
		imm12 = 12'(lcg_next() >> 8);
		return {{(xlen-12){imm12[11]}}, imm12};
	endfunction

	task automatic next_cycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic strobe_dispatch(input lgcmp_op_t op, input preg_t rd, input preg_t rs1,
		input preg_t rs2, input logic [xlen-1:0] imm);
		dispatch_valid = 1'b1;
		dispatch_info.op = op;
		dispatch_info.pc = rand64();
		dispatch_info.imm = imm;
		dispatch_info.rd = rd;
		dispatch_info.rs1 = rs1;
		dispatch_info.rs2 = rs2;
		next_cycle();
		dispatch_valid = 1'b0;
	endtask

	task automatic dispatch_tracked(input lgcmp_op_t op, input preg_t rd, input preg_t rs1,
		input preg_t rs2, input logic [xlen-1:0] imm);
		while (dispatch_full) begin
			next_cycle();
		end
		expected[rd] = reference_result(op, model_regs[rs1], model_regs[rs2], imm);
		model_regs[rd] = expected[rd];
		known[rd] = 1'b1;
		pending[rd] = 1'b1;
		src1[rd] = rs1;
		src2[rd] = rs2;
		readers[rs1]++;
		readers[rs2]++;
		accepted++;
		last_rd = rd;
		strobe_dispatch(op, rd, rs1, rs2, imm);
	endtask

	task automatic ext_write(input preg_t rd, input logic [xlen-1:0] data);
		ext_wb_valid = 1'b1;
		ext_wb.rd = rd;
		ext_wb.data = data;
		next_cycle();
		ext_wb_valid = 1'b0;
		model_regs[rd] = data;
		known[rd] = 1'b1;
	endtask

	task automatic flush_pulse();
		flush = 1'b1;
		next_cycle();
		flush = 1'b0;
	endtask

	// A dispatch killed by flush leaves its destination flag cleared
	task automatic clear_flag_by_flush(input preg_t rd);
		strobe_dispatch(op_xor, rd, '0, '0, '0);
		flush_pulse();
		known[rd] = 1'b0;
	endtask

	task automatic wait_drain();
		while (accepted != wb_count) begin
			next_cycle();
		end
	endtask

	task automatic run_random(input int count);
		lgcmp_op_t op;
		preg_t rs1;
		preg_t rs2;
		for (int n = 0; n < count; n++) begin
			op = lgcmp_op_t'(4'((lcg_next() >> 16) % 10));
			rs1 = pick_source();
			if (n % 4 == 3 && known[last_rd]) begin
				rs1 = last_rd; // Back-to-back dependency on the previous result
			end
			rs2 = pick_source();
			dispatch_tracked(op, pick_dest(rs1, rs2), rs1, rs2, rand_imm());
		end
	endtask

	// ----------------------------------------------------------
	// Writeback checks and run limit
	// ----------------------------------------------------------

	always @(negedge CLK) begin
		if (lgcmp_top_inst.props_inst.property_failed) begin
			abort_run("A concurrent property of the issue path failed");
		end else if (!reset && wb_valid) begin
			assert (pending[wb.rd]) else
				abort_run($sformatf("Writeback to p%0d with no instruction in flight", wb.rd));
			assert (wb.data == expected[wb.rd]) else
				abort_run($sformatf("CHECK FAILED wb.data (p%0d): got %h expected %h",
					wb.rd, wb.data, expected[wb.rd]));
			pending[wb.rd] = 1'b0;
			readers[src1[wb.rd]]--;
			readers[src2[wb.rd]]--;
			wb_count++;
		end
	end

	always @(posedge CLK) begin
		cycle_count++;
		if (cycle_count >= max_cycles) begin
			abort_run("Timeout: the run did not finish within the cycle limit");
		end
	end

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------

	initial begin
		reset = 1'b1;
		flush = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_info = '0;
		ext_wb_valid = 1'b0;
		ext_wb = '0;
		lcg_state = 32'd10;
		last_rd = '0;
		for (int i = 0; i < npreg; i++) begin
			model_regs[i] = '0;
			expected[i] = '0;
			known[i] = 1'b1; // Reset leaves every register zero and written back
			pending[i] = 1'b0;
			readers[i] = 0;
		end
		repeat (2) @(posedge CLK);
		#1;
		reset = 1'b0;
		assert (!dispatch_full && !wb_valid) else
			abort_run($sformatf("CHECK FAILED dispatch_full, wb_valid after reset: got %h, %h",
				dispatch_full, wb_valid));

		// Half the sources get the sign bit so signed and unsigned compares disagree
		for (int i = 2; i < npreg; i++) begin
			ext_write(preg_t'(i), rand64() | {i[0], {(xlen-1){1'b0}}});
		end
		run_random(40);

		// Fill the buffer behind an unwritten source
		wait_drain();
		hold = pick_dest('0, '0);
		clear_flag_by_flush(hold);
		hold_value = rand64();
		model_regs[hold] = hold_value;
		known[hold] = 1'b1;
		for (int n = 0; n < DP; n++) begin
			fill_src = pick_source();
			dispatch_tracked(lgcmp_op_t'(4'(n * 2 + 1)), pick_dest(hold, fill_src), hold,
				fill_src, rand_imm());
		end
		assert (dispatch_full) else
			abort_run($sformatf("CHECK FAILED dispatch_full: got %h expected 1", dispatch_full));
		strobe_dispatch(op_or, pick_dest(hold, hold), '0, '0, '0); // Dropped while full
		repeat (3) next_cycle();
		ext_write(hold, hold_value);
		wait_drain();

		// One entry is already in execute and one waits on gate when the flush lands
		gate = pick_dest('0, '0);
		clear_flag_by_flush(gate);
		kill_rd[0] = pick_dest(gate, gate);
		kill_rd[1] = pick_dest(gate, kill_rd[0]);
		for (int n = 0; n < 2; n++) begin
			strobe_dispatch(op_and, kill_rd[n], (n == 0) ? '0 : gate, '0, '0);
			known[kill_rd[n]] = 1'b0;
		end
		flush_pulse();
		ext_write(gate, rand64());
		repeat (6) next_cycle();

		run_random(30);
		wait_drain();
		repeat (5) next_cycle();
		if (wb_count != accepted) begin
			abort_run($sformatf("CHECK FAILED wb_count: got %h expected %h", wb_count, accepted));
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* lgcmp_top.f */
hw/lgcmp_pkg.sv
hw/lgcmp_issue_buffer.sv
hw/lgcmp_issue.sv
hw/lgcmp_execute.sv
hw/lgcmp_phys_regfile.sv
hw/lgcmp_top.sv
bench/lgcmp_properties.sv
bench/lgcmp_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the logic and compare issue path simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -j 0 -f lgcmp_top.f --top-module lgcmp_tb -o lgcmp_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/lgcmp_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
	exit 0
fi
exit 1
